/* files.f */
cache_pkg.sv
mem_if.sv
cache_array.sv
icache.sv
dcache.sv
mem_arb.sv
cache_top.sv
cache_chk.sv
tb_cache_scoreboard.sv
tb_cache_top.sv

/* Bender.yml */
package:
  name: l1_cache_subsys

sources:
  - cache_pkg.sv
  - mem_if.sv
  - cache_array.sv
  - icache.sv
  - dcache.sv
  - mem_arb.sv
  - cache_top.sv
  - target: test
    files:
      - cache_chk.sv
      - tb_cache_scoreboard.sv
      - tb_cache_top.sv

/* tb_cache_top.sv */
//**********************************************************
// testbench for the split L1 cache subsystem
// memory model with random stalls, directed and random core traffic
//**********************************************************
`timescale 1ns/1ps

module tb_cache_top;

    localparam logic [31:0] IBASE  = 32'h0000_4000;  // instruction region
    localparam logic [31:0] DBASE  = 32'h0010_0000;  // data region
    localparam int          N_RAND = 150;            // random requests per side
    localparam int          N_REQ  = 16 + 32 + 4 + 8 + 2 * N_RAND;
    localparam int          LIMIT  = 200 * N_REQ;    // cycles before timeout

    logic        clk = 1'b0;
    logic        rst_n;
    logic        i_if_valid, o_if_ready, o_if_rvalid;
    logic [31:0] i_if_addr, o_if_rdata;
    logic        i_d_valid, i_d_we, o_d_ready, o_d_done;
    logic [31:0] i_d_addr, i_d_wdata, o_d_rdata;
    logic        o_mem_req_valid, i_mem_req_ready, o_mem_req_we, i_mem_rsp_valid;
    logic [31:0] o_mem_req_addr, o_mem_req_wdata, i_mem_rsp_rdata;
    logic [31:0] mem_image [logic [31:0]];  // sparse memory contents
    integer      seed = 32'h9951;
    int          sb_errors, sb_checks;

    always #10 clk = ~clk;

    cache_top dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_if_valid      (i_if_valid),
        .i_if_addr       (i_if_addr),
        .o_if_ready      (o_if_ready),
        .o_if_rvalid     (o_if_rvalid),
        .o_if_rdata      (o_if_rdata),
        .i_d_valid       (i_d_valid),
        .i_d_we          (i_d_we),
        .i_d_addr        (i_d_addr),
        .i_d_wdata       (i_d_wdata),
        .o_d_ready       (o_d_ready),
        .o_d_done        (o_d_done),
        .o_d_rdata       (o_d_rdata),
        .o_mem_req_valid (o_mem_req_valid),
        .i_mem_req_ready (i_mem_req_ready),
        .o_mem_req_we    (o_mem_req_we),
        .o_mem_req_addr  (o_mem_req_addr),
        .o_mem_req_wdata (o_mem_req_wdata),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .i_mem_rsp_rdata (i_mem_rsp_rdata)
    );

    tb_cache_scoreboard u_sb (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_if_valid      (i_if_valid),
        .i_if_addr       (i_if_addr),
        .i_if_ready      (o_if_ready),
        .i_if_rvalid     (o_if_rvalid),
        .i_if_rdata      (o_if_rdata),
        .i_d_valid       (i_d_valid),
        .i_d_we          (i_d_we),
        .i_d_addr        (i_d_addr),
        .i_d_wdata       (i_d_wdata),
        .i_d_ready       (o_d_ready),
        .i_d_done        (o_d_done),
        .i_d_rdata       (o_d_rdata),
        .i_mem_req_valid (o_mem_req_valid),
        .i_mem_req_ready (i_mem_req_ready),
        .i_mem_req_we    (o_mem_req_we),
        .i_mem_req_addr  (o_mem_req_addr),
        .i_mem_req_wdata (o_mem_req_wdata),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .o_errors        (sb_errors),
        .o_checks        (sb_checks)
    );

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (mem_image.exists(addr))
            return mem_image[addr];
        return addr ^ 32'hA5A50000;
    endfunction

    // one request at a time, answered 1 to 4 cycles after acceptance
    initial begin : memory_model
        logic        take, t_we;
        logic [31:0] t_addr, t_wdata, rsp_data;
        int          rsp_wait;
        i_mem_req_ready = 1'b0;
        i_mem_rsp_valid = 1'b0;
        i_mem_rsp_rdata = '0;
        rsp_data        = '0;
        rsp_wait        = 0;
        forever begin
            @(negedge clk);
            take    = rst_n && o_mem_req_valid && i_mem_req_ready;
            t_we    = o_mem_req_we;
            t_addr  = o_mem_req_addr;
            t_wdata = o_mem_req_wdata;
            @(posedge clk);
            #2;
            i_mem_rsp_valid = 1'b0;
            if (take) begin
                if (t_we)
                    mem_image[t_addr] = t_wdata;
                rsp_data = mem_word(t_addr);
                rsp_wait = 1 + {$random(seed)} % 4;
            end
            if (rsp_wait > 0) begin
                rsp_wait--;
                if (rsp_wait == 0) begin
                    i_mem_rsp_valid = 1'b1;
                    i_mem_rsp_rdata = rsp_data;
                end
            end
            i_mem_req_ready = ({$random(seed)} % 4) != 0;  // stall about one cycle in four
        end
    end

    task automatic fetch(input logic [31:0] addr);
        @(posedge clk);
        #2;
        i_if_valid = 1'b1;
        i_if_addr  = addr;
        @(negedge clk);
        while (!o_if_ready)
            @(negedge clk);
        @(posedge clk);
        #2;
        i_if_valid = 1'b0;
        @(negedge clk);
        while (!o_if_rvalid)
            @(negedge clk);
    endtask

    task automatic data_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata);
        @(posedge clk);
        #2;
        i_d_valid = 1'b1;
        i_d_we    = we;
        i_d_addr  = addr;
        i_d_wdata = wdata;
        @(negedge clk);
        while (!o_d_ready)
            @(negedge clk);
        @(posedge clk);
        #2;
        i_d_valid = 1'b0;
        @(negedge clk);
        while (!o_d_done)
            @(negedge clk);
    endtask

    initial begin : stimulus
        int total;
        rst_n      = 1'b0;
        i_if_valid = 1'b0;
        i_if_addr  = '0;
        i_d_valid  = 1'b0;
        i_d_we     = 1'b0;
        i_d_addr   = '0;
        i_d_wdata  = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (3) @(posedge clk);  // idle outputs before any request

        // instruction misses, then the same words as hits
        for (int k = 0; k < 8; k++) begin
            fetch(IBASE + 4 * k);
            fetch(IBASE + 4 * k);
        end

        // writes read back, again after unrelated traffic
        for (int k = 0; k < 8; k++)
            data_access(1'b1, DBASE + 4 * k, 32'hD000_0000 + k);
        for (int k = 0; k < 8; k++)
            data_access(1'b0, DBASE + 4 * k, '0);
        for (int k = 8; k < 12; k++) begin
            fetch(IBASE + 4 * k);
            data_access(1'b1, DBASE + 4 * k, 32'hD100_0000 + k);
        end
        for (int k = 0; k < 8; k++)
            data_access(1'b0, DBASE + 4 * k, '0);

        // conflicting indexes force dirty victims out
        data_access(1'b1, DBASE + 32'h40, 32'hE000_0040);
        data_access(1'b0, DBASE, '0);
        data_access(1'b0, DBASE + 32'h40, '0);
        data_access(1'b0, DBASE + 32'h84, '0);  // index 1, dirty DBASE+4 goes back

        // both sides miss at the same time
        fork
            for (int k = 0; k < 4; k++)
                fetch(IBASE + 32'h100 + 4 * k);
            for (int k = 0; k < 4; k++)
                data_access(1'b0, DBASE + 32'h200 + 4 * k, '0);
        join

        // random mixed traffic over 64 words per side
        fork
            begin
                int k;
                for (int n = 0; n < N_RAND; n++) begin
                    k = {$random(seed)} % 64;
                    fetch(IBASE + 4 * k);
                end
            end
            begin
                int   j;
                logic we;
                for (int n = 0; n < N_RAND; n++) begin
                    j  = {$random(seed)} % 64;
                    we = ({$random(seed)} % 2) == 1;
                    data_access(we, DBASE + 4 * j, $random(seed));
                end
            end
        join

        repeat (5) @(posedge clk);
        total = sb_errors + dut_i.u_chk.fail_count;
        $display("checks %0d, scoreboard errors %0d, assertion failures %0d",
                 sb_checks, sb_errors, dut_i.u_chk.fail_count);
        if (total == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the DUT stopped answering after %0d cycles", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* tb_cache_scoreboard.sv */
//**********************************************************
// scoreboard for the cache subsystem
// checks core answers and memory traffic against a reference image
//**********************************************************
`timescale 1ns/1ps

module tb_cache_scoreboard (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_if_valid,
    input  logic [cache_pkg::ADDR_W-1:0] i_if_addr,
    input  logic                         i_if_ready,
    input  logic                         i_if_rvalid,
    input  logic [cache_pkg::DATA_W-1:0] i_if_rdata,
    input  logic                         i_d_valid,
    input  logic                         i_d_we,
    input  logic [cache_pkg::ADDR_W-1:0] i_d_addr,
    input  logic [cache_pkg::DATA_W-1:0] i_d_wdata,
    input  logic                         i_d_ready,
    input  logic                         i_d_done,
    input  logic [cache_pkg::DATA_W-1:0] i_d_rdata,
    input  logic                         i_mem_req_valid,
    input  logic                         i_mem_req_ready,
    input  logic                         i_mem_req_we,
    input  logic [cache_pkg::ADDR_W-1:0] i_mem_req_addr,
    input  logic [cache_pkg::DATA_W-1:0] i_mem_req_wdata,
    input  logic                         i_mem_rsp_valid,
    output int                           o_errors,
    output int                           o_checks
);

    logic [31:0] core_image [logic [31:0]];  // last core write per address
    logic        itag_valid [cache_pkg::LINES];
    logic [25:0] itag [cache_pkg::LINES];    // expected icache contents
    logic [31:0] if_addr, d_addr, d_wdata;
    logic        d_we, if_hit, if_busy, d_busy, mem_busy, started;
    int          if_wait;
    int          errors = 0;
    int          checks = 0;

    assign o_errors = errors;
    assign o_checks = checks;

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        if (core_image.exists(addr))
            return core_image[addr];
        return addr ^ 32'hA5A50000;  // untouched memory
    endfunction

    task automatic compare(input string name, input logic [31:0] addr,
                           input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s at addr %h: got %h expected %h", name, addr, got, exp);
        end
    endtask

    task automatic flag_error(input string what);
        errors++;
        $display("%0d ns: %s", $time, what);
    endtask

    // sampled at the falling edge, away from the DUT's own updates
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_busy  = 1'b0;
            d_busy   = 1'b0;
            mem_busy = 1'b0;
            started  = 1'b0;
            for (int i = 0; i < cache_pkg::LINES; i++)
                itag_valid[i] = 1'b0;
        end else begin
            if (!started && (!i_if_ready || !i_d_ready || i_if_rvalid || i_d_done
                             || i_mem_req_valid))
                flag_error("outputs left their idle state before the first request");
            if (if_busy)
                if_wait++;
            if (i_if_rvalid) begin
                if (!if_busy) begin
                    flag_error("instruction response without a request");
                end else begin
                    compare("o_if_rdata", if_addr, i_if_rdata, ref_read(if_addr));
                    if (if_hit && if_wait != 1)
                        flag_error($sformatf("instruction hit at %h took %0d cycles",
                                             if_addr, if_wait));
                    itag_valid[if_addr[5:2]] = 1'b1;
                    itag[if_addr[5:2]]       = if_addr[31:6];
                    if_busy = 1'b0;
                end
            end
            if (i_if_valid && i_if_ready) begin
                if_addr = i_if_addr;
                if_hit  = itag_valid[i_if_addr[5:2]] && itag[i_if_addr[5:2]] == i_if_addr[31:6];
                if_wait = 0;
                if_busy = 1'b1;
                started = 1'b1;
            end
            if (i_d_done) begin
                if (!d_busy)
                    flag_error("data done without a request");
                else if (d_we)
                    core_image[d_addr] = d_wdata;
                else
                    compare("o_d_rdata", d_addr, i_d_rdata, ref_read(d_addr));
                d_busy = 1'b0;
            end
            if (i_d_valid && i_d_ready) begin
                d_addr  = i_d_addr;
                d_we    = i_d_we;
                d_wdata = i_d_wdata;
                d_busy  = 1'b1;
                started = 1'b1;
            end
            if (i_mem_rsp_valid)
                mem_busy = 1'b0;
            if (i_mem_req_valid && i_mem_req_ready) begin
                if (mem_busy)
                    flag_error("second memory request while one is outstanding");
                mem_busy = 1'b1;
                if (i_mem_req_we) begin  // victim write-back
                    if (!core_image.exists(i_mem_req_addr))
                        flag_error("write-back of an address the core never wrote");
                    compare("o_mem_req_wdata", i_mem_req_addr, i_mem_req_wdata,
                            ref_read(i_mem_req_addr));
                end
            end
        end
    end

endmodule

/* cache_chk.sv */
//**********************************************************
// bound checker for the cache subsystem
// memory handshake rules and the state right after reset
//**********************************************************
`timescale 1ns/1ps

module cache_chk (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         i_req_valid,
    input logic                         i_req_ready,
    input logic                         i_req_we,
    input logic [cache_pkg::ADDR_W-1:0] i_req_addr,
    input logic [cache_pkg::DATA_W-1:0] i_req_wdata,
    input logic                         i_rsp_valid,
    input logic                         i_ic_req_valid,  // icache side of the arbiter
    input logic                         i_ic_req_ready,
    input logic                         i_ic_rsp_valid,
    input logic                         i_dc_req_valid,  // dcache side of the arbiter
    input logic                         i_dc_req_ready,
    input logic                         i_dc_rsp_valid,
    input logic                         i_if_ready,
    input logic                         i_if_rvalid,
    input logic                         i_d_ready,
    input logic                         i_d_done
);

    int   fail_count = 0;
    logic ic_pending;  // icache request accepted, response not yet seen
    logic dc_pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ic_pending <= 1'b0;
            dc_pending <= 1'b0;
        end else begin
            if (i_ic_req_valid && i_ic_req_ready)
                ic_pending <= 1'b1;
            else if (i_ic_rsp_valid)
                ic_pending <= 1'b0;
            if (i_dc_req_valid && i_dc_req_ready)
                dc_pending <= 1'b1;
            else if (i_dc_rsp_valid)
                dc_pending <= 1'b0;
        end
    end

    // a stalled request keeps valid and payload
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        i_req_valid && !i_req_ready
            |=> i_req_valid && $stable({i_req_we, i_req_addr, i_req_wdata}))
        else begin
            fail_count++;
            $error("memory request changed while stalled");
        end

    // each memory response reaches only the cache that waits for it
    rsp_expected: assert property (@(posedge clk) disable iff (!rst_n)
        (!i_ic_rsp_valid || ic_pending) && (!i_dc_rsp_valid || dc_pending)
            && ($countones({i_ic_rsp_valid, i_dc_rsp_valid}) == i_rsp_valid))
        else begin
            fail_count++;
            $error("memory response without an outstanding request");
        end

    reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> i_if_ready && i_d_ready && !i_if_rvalid && !i_d_done && !i_req_valid)
        else begin
            fail_count++;
            $error("outputs not idle after reset");
        end

endmodule

bind cache_top cache_chk u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_req_valid    (o_mem_req_valid),
    .i_req_ready    (i_mem_req_ready),
    .i_req_we       (o_mem_req_we),
    .i_req_addr     (o_mem_req_addr),
    .i_req_wdata    (o_mem_req_wdata),
    .i_rsp_valid    (i_mem_rsp_valid),
    .i_ic_req_valid (i_mem.req_valid),
    .i_ic_req_ready (i_mem.req_ready),
    .i_ic_rsp_valid (i_mem.rsp_valid),
    .i_dc_req_valid (d_mem.req_valid),
    .i_dc_req_ready (d_mem.req_ready),
    .i_dc_rsp_valid (d_mem.rsp_valid),
    .i_if_ready     (o_if_ready),
    .i_if_rvalid    (o_if_rvalid),
    .i_d_ready      (o_d_ready),
    .i_d_done       (o_d_done)
);

/* cache_top.sv */
//**********************************************************
// split L1 cache subsystem
// icache and dcache sharing one memory port through the arbiter
//**********************************************************
`timescale 1ns/1ps

module cache_top (
    input  logic                         clk,
    input  logic                         rst_n,
    // instruction side
    input  logic                         i_if_valid,
    input  logic [cache_pkg::ADDR_W-1:0] i_if_addr,
    output logic                         o_if_ready,
    output logic                         o_if_rvalid,
    output logic [cache_pkg::DATA_W-1:0] o_if_rdata,
    // data side
    input  logic                         i_d_valid,
    input  logic                         i_d_we,
    input  logic [cache_pkg::ADDR_W-1:0] i_d_addr,
    input  logic [cache_pkg::DATA_W-1:0] i_d_wdata,
    output logic                         o_d_ready,
    output logic                         o_d_done,
    output logic [cache_pkg::DATA_W-1:0] o_d_rdata,
    // shared memory
    output logic                         o_mem_req_valid,
    input  logic                         i_mem_req_ready,
    output logic                         o_mem_req_we,
    output logic [cache_pkg::ADDR_W-1:0] o_mem_req_addr,
    output logic [cache_pkg::DATA_W-1:0] o_mem_req_wdata,
    input  logic                         i_mem_rsp_valid,
    input  logic [cache_pkg::DATA_W-1:0] i_mem_rsp_rdata
);

    mem_if i_mem ();
    mem_if d_mem ();

    icache u_icache (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_if_valid  (i_if_valid),
        .i_if_addr   (i_if_addr),
        .o_if_ready  (o_if_ready),
        .o_if_rvalid (o_if_rvalid),
        .o_if_rdata  (o_if_rdata),
        .mem         (i_mem.master)
    );

    dcache u_dcache (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_d_valid (i_d_valid),
        .i_d_we    (i_d_we),
        .i_d_addr  (i_d_addr),
        .i_d_wdata (i_d_wdata),
        .o_d_ready (o_d_ready),
        .o_d_done  (o_d_done),
        .o_d_rdata (o_d_rdata),
        .mem       (d_mem.master)
    );

    mem_arb u_arb (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_port          (i_mem.slave),
        .d_port          (d_mem.slave),
        .o_mem_req_valid (o_mem_req_valid),
        .i_mem_req_ready (i_mem_req_ready),
        .o_mem_req_we    (o_mem_req_we),
        .o_mem_req_addr  (o_mem_req_addr),
        .o_mem_req_wdata (o_mem_req_wdata),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .i_mem_rsp_rdata (i_mem_rsp_rdata)
    );

endmodule

/* mem_arb.sv */
//**********************************************************
// memory arbiter
// two caches onto one memory port, data side wins ties
//**********************************************************
`timescale 1ns/1ps

module mem_arb (
    input  logic                         clk,
    input  logic                         rst_n,
    mem_if.slave                         i_port,
    mem_if.slave                         d_port,
    output logic                         o_mem_req_valid,
    input  logic                         i_mem_req_ready,
    output logic                         o_mem_req_we,
    output logic [cache_pkg::ADDR_W-1:0] o_mem_req_addr,
    output logic [cache_pkg::DATA_W-1:0] o_mem_req_wdata,
    input  logic                         i_mem_rsp_valid,
    input  logic [cache_pkg::DATA_W-1:0] i_mem_rsp_rdata
);

    logic busy;   // accepted request waiting for its response
    logic hold;   // request shown last cycle without ready
    logic own_d;  // owner of the port, 1 = data cache
    logic sel_d;

    // keep the choice while stalled or outstanding
    assign sel_d = (busy || hold) ? own_d : d_port.req_valid;

    assign o_mem_req_valid = !busy && (sel_d ? d_port.req_valid : i_port.req_valid);
    assign o_mem_req_we    = sel_d ? d_port.req_we    : i_port.req_we;
    assign o_mem_req_addr  = sel_d ? d_port.req_addr  : i_port.req_addr;
    assign o_mem_req_wdata = sel_d ? d_port.req_wdata : i_port.req_wdata;

    assign d_port.req_ready = !busy && sel_d && i_mem_req_ready;
    assign i_port.req_ready = !busy && !sel_d && i_mem_req_ready;

    // response only to the owner
    assign d_port.rsp_valid = i_mem_rsp_valid && busy && own_d;
    assign i_port.rsp_valid = i_mem_rsp_valid && busy && !own_d;
    assign d_port.rsp_rdata = i_mem_rsp_rdata;
    assign i_port.rsp_rdata = i_mem_rsp_rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            hold  <= 1'b0;
            own_d <= 1'b0;
        end else begin
            hold <= o_mem_req_valid && !i_mem_req_ready;
            if (o_mem_req_valid)
                own_d <= sel_d;
            if (o_mem_req_valid && i_mem_req_ready)
                busy <= 1'b1;
            else if (i_mem_rsp_valid)
                busy <= 1'b0;
        end
    end

endmodule

/* dcache.sv */
//**********************************************************
// data cache
// direct mapped write back, write allocate without fill
//**********************************************************
`timescale 1ns/1ps

module dcache (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_d_valid,
    input  logic                         i_d_we,
    input  logic [cache_pkg::ADDR_W-1:0] i_d_addr,
    input  logic [cache_pkg::DATA_W-1:0] i_d_wdata,
    output logic                         o_d_ready,
    output logic                         o_d_done,
    output logic [cache_pkg::DATA_W-1:0] o_d_rdata,
    mem_if.master                        mem
);

    cache_pkg::cache_state_t      state, nxt_state;
    cache_pkg::dcache_line_t      rline, wline;
    logic [cache_pkg::ADDR_W-1:0] addr_q;
    logic [cache_pkg::DATA_W-1:0] wdata_q;
    logic                         we_q;
    logic [cache_pkg::IDX_W-1:0]  idx_q;
    logic [cache_pkg::TAG_W-1:0]  tag_q;
    logic                         sent;
    logic                         hit;
    logic                         line_we;
    logic                         is_alloc;
    logic                         is_wb;

    cache_array #(.line_t(cache_pkg::dcache_line_t)) u_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_idx   (idx_q),
        .i_we    (line_we),
        .i_wline (wline),
        .o_rline (rline)
    );

    assign idx_q    = addr_q[cache_pkg::IDX_W+1:2];
    assign tag_q    = addr_q[cache_pkg::ADDR_W-1:cache_pkg::IDX_W+2];
    assign hit      = rline.valid && (rline.tag == tag_q);
    assign is_alloc = (state == cache_pkg::ALLOC);
    assign is_wb    = (state == cache_pkg::WRITEBACK);

    // fill from memory is clean, a core write is dirty
    assign wline = is_alloc ? '{valid: 1'b1, dirty: 1'b0, tag: tag_q, data: mem.rsp_rdata}
                            : '{valid: 1'b1, dirty: 1'b1, tag: tag_q, data: wdata_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cache_pkg::IDLE;
            sent  <= 1'b0;
        end else begin
            state <= nxt_state;
            if (mem.rsp_valid)
                sent <= 1'b0;
            else if (mem.req_valid && mem.req_ready)
                sent <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (o_d_ready && i_d_valid) begin
            addr_q  <= i_d_addr;
            wdata_q <= i_d_wdata;
            we_q    <= i_d_we;
        end
    end

    always_comb begin
        nxt_state = state;
        o_d_done  = 1'b0;
        line_we   = 1'b0;
        case (state)
            cache_pkg::IDLE: if (i_d_valid) nxt_state = cache_pkg::COMPARE;
            cache_pkg::COMPARE: begin
                if (hit || (we_q && !(rline.valid && rline.dirty))) begin
                    line_we   = we_q;  // write hit or clean write miss installs
                    o_d_done  = 1'b1;
                    nxt_state = cache_pkg::IDLE;
                end else if (rline.valid && rline.dirty) begin
                    nxt_state = cache_pkg::WRITEBACK;
                end else begin
                    nxt_state = cache_pkg::ALLOC;
                end
            end
            cache_pkg::WRITEBACK: begin
                if (mem.rsp_valid) begin  // victim ack
                    line_we   = we_q;
                    o_d_done  = we_q;
                    nxt_state = we_q ? cache_pkg::IDLE : cache_pkg::ALLOC;
                end
            end
            cache_pkg::ALLOC: begin
                if (mem.rsp_valid) begin
                    line_we   = 1'b1;
                    o_d_done  = 1'b1;
                    nxt_state = cache_pkg::IDLE;
                end
            end
            default: nxt_state = cache_pkg::IDLE;
        endcase
    end

    assign o_d_ready     = (state == cache_pkg::IDLE);
    assign o_d_rdata     = is_alloc ? mem.rsp_rdata : rline.data;
    assign mem.req_valid = (is_alloc || is_wb) && !sent;
    assign mem.req_we    = is_wb;
    // victim goes back to its own address
    assign mem.req_addr  = is_wb ? {rline.tag, idx_q, 2'b00} : {tag_q, idx_q, 2'b00};
    assign mem.req_wdata = rline.data;

endmodule

/* icache.sv */
//**********************************************************
// instruction cache
// direct mapped, read only, fills one word from memory on a miss
//**********************************************************
`timescale 1ns/1ps

module icache (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_if_valid,
    input  logic [cache_pkg::ADDR_W-1:0] i_if_addr,
    output logic                         o_if_ready,
    output logic                         o_if_rvalid,
    output logic [cache_pkg::DATA_W-1:0] o_if_rdata,
    mem_if.master                        mem
);

    cache_pkg::cache_state_t      state, nxt_state;
    cache_pkg::icache_line_t      rline, wline;
    logic [cache_pkg::ADDR_W-1:0] addr_q;
    logic [cache_pkg::IDX_W-1:0]  idx_q;
    logic [cache_pkg::TAG_W-1:0]  tag_q;
    logic                         sent;      // fill read accepted by memory
    logic                         hit;
    logic                         line_we;

    cache_array #(.line_t(cache_pkg::icache_line_t)) u_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_idx   (idx_q),
        .i_we    (line_we),
        .i_wline (wline),
        .o_rline (rline)
    );

    assign idx_q = addr_q[cache_pkg::IDX_W+1:2];
    assign tag_q = addr_q[cache_pkg::ADDR_W-1:cache_pkg::IDX_W+2];
    assign hit   = rline.valid && (rline.tag == tag_q);
    assign wline = '{valid: 1'b1, tag: tag_q, data: mem.rsp_rdata};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cache_pkg::IDLE;
            sent  <= 1'b0;
        end else begin
            state <= nxt_state;
            if (mem.rsp_valid)
                sent <= 1'b0;
            else if (mem.req_valid && mem.req_ready)
                sent <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (o_if_ready && i_if_valid)
            addr_q <= i_if_addr;  // request accepted
    end

    always_comb begin
        nxt_state   = state;
        o_if_rvalid = 1'b0;
        line_we     = 1'b0;
        case (state)
            cache_pkg::IDLE: if (i_if_valid) nxt_state = cache_pkg::COMPARE;
            cache_pkg::COMPARE: begin
                if (hit) begin
                    o_if_rvalid = 1'b1;
                    nxt_state   = cache_pkg::IDLE;
                end else begin
                    nxt_state   = cache_pkg::ALLOC;
                end
            end
            cache_pkg::ALLOC: begin
                if (mem.rsp_valid) begin  // fill and answer the core together
                    line_we     = 1'b1;
                    o_if_rvalid = 1'b1;
                    nxt_state   = cache_pkg::IDLE;
                end
            end
            default: nxt_state = cache_pkg::IDLE;  // no writeback here
        endcase
    end

    assign o_if_ready    = (state == cache_pkg::IDLE);
    assign o_if_rdata    = (state == cache_pkg::ALLOC) ? mem.rsp_rdata : rline.data;
    assign mem.req_valid = (state == cache_pkg::ALLOC) && !sent;
    assign mem.req_we    = 1'b0;
    assign mem.req_addr  = {tag_q, idx_q, 2'b00};
    assign mem.req_wdata = '0;

endmodule

/* cache_array.sv */
//**********************************************************
// cache line store
// register file, async read and clocked write at one index
//**********************************************************
`timescale 1ns/1ps

module cache_array #(
    parameter type line_t = cache_pkg::icache_line_t
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [cache_pkg::IDX_W-1:0] i_idx,
    input  logic                        i_we,
    input  line_t                       i_wline,
    output line_t                       o_rline
);

    line_t lines [cache_pkg::LINES];

    // all lines come out of reset invalid and clean
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cache_pkg::LINES; i++) begin
                lines[i] <= '0;
            end
        end else if (i_we) begin
            lines[i_idx] <= i_wline;
        end
    end

    assign o_rline = lines[i_idx];  // same index as the write port

endmodule

/* mem_if.sv */
//**********************************************************
// memory channel between one cache and the arbiter
//**********************************************************
`timescale 1ns/1ps

interface mem_if;

    logic                         req_valid;
    logic                         req_ready;
    logic                         req_we;     // 1 = writeback
    logic [cache_pkg::ADDR_W-1:0] req_addr;
    logic [cache_pkg::DATA_W-1:0] req_wdata;
    logic                         rsp_valid;  // read data or write ack
    logic [cache_pkg::DATA_W-1:0] rsp_rdata;

    // cache side
    modport master (output req_valid, req_we, req_addr, req_wdata,
                    input  req_ready, rsp_valid, rsp_rdata);

    // arbiter side, used for both the i and d ports
    modport slave  (input  req_valid, req_we, req_addr, req_wdata,
                    output req_ready, rsp_valid, rsp_rdata);

endinterface

/* cache_pkg.sv */
//**********************************************************
// cache package
// shared widths, line layouts and controller states for both L1 caches
//**********************************************************
package cache_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int IDX_W  = 4;                  // addr[5:2]
    localparam int LINES  = 16;
    localparam int TAG_W  = 26;                 // addr[31:6]

    // instruction line, 59 bits
    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } icache_line_t;

    // data line, 60 bits
    typedef struct packed {
        logic              valid;
        logic              dirty;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } dcache_line_t;

    typedef enum logic [1:0] {IDLE, COMPARE, ALLOC, WRITEBACK} cache_state_t;

endpackage
